//--- common/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

`define ADDR_W    32
`define DATA_W    32
`define ID_W      4

`define MEM_WORDS 1024 // Byte addresses below 4096
`define SRAM_LAT  3    // Accept to response valid

`define IFU_ID    0
`define LSU_ID    1

`endif

//--- common/axi_pkg.sv
package axi_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_t;

	typedef enum logic [2:0] {
		SZ_BYTE = 3'd0,
		SZ_HALF = 3'd1,
		SZ_WORD = 3'd2
	} axi_size_t;

	localparam logic [1:0] BURST_INCR = 2'b01;

endpackage

//--- common/mem_pkg.sv
package mem_pkg;

	typedef enum logic [3:0] {LB, LH, LW, LBU, LHU, SB, SH, SW} lsu_op_t;

	function automatic logic op_is_store(input lsu_op_t op);
		return op inside {SB, SH, SW};
	endfunction

	// Access width of an opcode as an AXI size
	function automatic axi_pkg::axi_size_t op_size(input lsu_op_t op);
		case (op)
			LB, LBU, SB: return axi_pkg::SZ_BYTE;
			LH, LHU, SH: return axi_pkg::SZ_HALF;
			default: return axi_pkg::SZ_WORD;
		endcase
	endfunction

endpackage

//--- hw/ifu_fetch_port.sv
`include "mem_config.svh"

module ifu_fetch_port import axi_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  fetch_req,
	input  logic [`ADDR_W-1:0]    fetch_addr,
	output logic                  fetch_busy,
	output logic                  fetch_done,
	output logic [`DATA_W-1:0]    fetch_data,
	output logic                  fetch_err,
	output logic [`ADDR_W-1:0]    ifu_araddr,
	output logic                  ifu_arvalid,
	input  logic                  ifu_arready,
	output logic [`ID_W-1:0]      ifu_arid,
	output logic [7:0]            ifu_arlen,
	output axi_size_t             ifu_arsize,
	output logic [1:0]            ifu_arburst,
	input  logic [`DATA_W-1:0]    ifu_rdata,
	input  axi_resp_t             ifu_rresp,
	input  logic                  ifu_rvalid,
	output logic                  ifu_rready,
	input  logic                  ifu_rlast,
	input  logic [`ID_W-1:0]      ifu_rid,
	output logic [`ADDR_W-1:0]    ifu_awaddr,
	output logic                  ifu_awvalid,
	input  logic                  ifu_awready,
	output logic [`ID_W-1:0]      ifu_awid,
	output logic [7:0]            ifu_awlen,
	output axi_size_t             ifu_awsize,
	output logic [1:0]            ifu_awburst,
	output logic [`DATA_W-1:0]    ifu_wdata,
	output logic [`DATA_W/8-1:0]  ifu_wstrb,
	output logic                  ifu_wvalid,
	output logic                  ifu_wlast,
	input  logic                  ifu_wready,
	input  axi_resp_t             ifu_bresp,
	input  logic                  ifu_bvalid,
	input  logic [`ID_W-1:0]      ifu_bid,
	output logic                  ifu_bready
);
	typedef enum logic [1:0] {IDLE, ADDR, RESP} state_t;

	state_t state;
	logic [`ADDR_W-1:0] addr_q;
	logic misaligned;

	assign misaligned = |fetch_addr[1:0];
	assign fetch_busy = state != IDLE;

	assign ifu_araddr  = addr_q;
	assign ifu_arvalid = state == ADDR;
	assign ifu_arid    = `ID_W'(`IFU_ID);
	assign ifu_arlen   = 8'd0;
	assign ifu_arsize  = SZ_WORD;
	assign ifu_arburst = BURST_INCR;
	assign ifu_rready  = state == RESP; // Never back-pressured

	// Read-only master
	assign ifu_awaddr  = '0;
	assign ifu_awvalid = 1'b0;
	assign ifu_awid    = `ID_W'(`IFU_ID);
	assign ifu_awlen   = 8'd0;
	assign ifu_awsize  = SZ_WORD;
	assign ifu_awburst = BURST_INCR;
	assign ifu_wdata   = '0;
	assign ifu_wstrb   = '0;
	assign ifu_wvalid  = 1'b0;
	assign ifu_wlast   = 1'b1;
	assign ifu_bready  = 1'b0;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= IDLE;
			fetch_done <= 1'b0;
			fetch_err <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				IDLE: begin
					if (fetch_req && misaligned) begin
						fetch_done <= 1'b1; // No bus access
						fetch_err <= 1'b1;
					end else if (fetch_req) begin
						state <= ADDR;
					end
				end
				ADDR: begin
					if (ifu_arready) begin
						state <= RESP;
					end
				end
				RESP: begin
					if (ifu_rvalid) begin
						fetch_done <= 1'b1;
						fetch_err <= ifu_rresp != OKAY || !ifu_rlast ||
							ifu_rid != `ID_W'(`IFU_ID);
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && fetch_req) begin
			addr_q <= fetch_addr;
		end
		if (state == IDLE && fetch_req && misaligned) begin
			fetch_data <= '0;
		end else if (state == RESP && ifu_rvalid) begin
			fetch_data <= ifu_rdata;
		end
	end

endmodule

//--- hw/lsu_access_port.sv
`include "mem_config.svh"

module lsu_access_port import axi_pkg::*, mem_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  lsu_req,
	input  lsu_op_t               lsu_op,
	input  logic [`ADDR_W-1:0]    lsu_addr,
	input  logic [`DATA_W-1:0]    lsu_wdata,
	output logic                  lsu_busy,
	output logic                  lsu_done,
	output logic [`DATA_W-1:0]    lsu_rdata,
	output logic                  lsu_err,
	output logic [`ADDR_W-1:0]    lsu_araddr,
	output logic                  lsu_arvalid,
	input  logic                  lsu_arready,
	output logic [`ID_W-1:0]      lsu_arid,
	output logic [7:0]            lsu_arlen,
	output axi_size_t             lsu_arsize,
	output logic [1:0]            lsu_arburst,
	input  logic [`DATA_W-1:0]    lsu_axi_rdata, // Bus data, apart from core-side lsu_rdata
	input  axi_resp_t             lsu_rresp,
	input  logic                  lsu_rvalid,
	output logic                  lsu_rready,
	input  logic                  lsu_rlast,
	input  logic [`ID_W-1:0]      lsu_rid,
	output logic [`ADDR_W-1:0]    lsu_awaddr,
	output logic                  lsu_awvalid,
	input  logic                  lsu_awready,
	output logic [`ID_W-1:0]      lsu_awid,
	output logic [7:0]            lsu_awlen,
	output axi_size_t             lsu_awsize,
	output logic [1:0]            lsu_awburst,
	output logic [`DATA_W-1:0]    lsu_axi_wdata,
	output logic [`DATA_W/8-1:0]  lsu_wstrb,
	output logic                  lsu_wvalid,
	output logic                  lsu_wlast,
	input  logic                  lsu_wready,
	input  axi_resp_t             lsu_bresp,
	input  logic                  lsu_bvalid,
	input  logic [`ID_W-1:0]      lsu_bid,
	output logic                  lsu_bready
);
	typedef enum logic [1:0] {IDLE, ADDR, RESP} state_t;

	state_t state;
	lsu_op_t op_q;
	logic [`ADDR_W-1:0] addr_q;
	logic [`DATA_W-1:0] wdata_q;
	logic [`DATA_W/8-1:0] strb_q;
	logic [`DATA_W-1:0] lane;
	logic [`DATA_W-1:0] load_val;
	logic store_q;
	logic misaligned;

	assign store_q = op_is_store(op_q);
	assign lsu_busy = state != IDLE;

	always_comb begin
		case (op_size(lsu_op))
			SZ_HALF: misaligned = lsu_addr[0];
			SZ_WORD: misaligned = |lsu_addr[1:0];
			default: misaligned = 1'b0;
		endcase
	end

	// Shift the addressed lane down, then extend by opcode
	always_comb begin
		lane = lsu_axi_rdata >> {addr_q[1:0], 3'b000};
		case (op_q)
			LB: load_val = {{(`DATA_W-8){lane[7]}}, lane[7:0]};
			LBU: load_val = {{(`DATA_W-8){1'b0}}, lane[7:0]};
			LH: load_val = {{(`DATA_W-16){lane[15]}}, lane[15:0]};
			LHU: load_val = {{(`DATA_W-16){1'b0}}, lane[15:0]};
			default: load_val = lane;
		endcase
	end

	assign lsu_araddr  = addr_q;
	assign lsu_arvalid = state == ADDR && !store_q;
	assign lsu_arid    = `ID_W'(`LSU_ID);
	assign lsu_arlen   = 8'd0;
	assign lsu_arsize  = op_size(op_q);
	assign lsu_arburst = BURST_INCR;
	assign lsu_rready  = state == RESP && !store_q;

	assign lsu_awaddr    = addr_q;
	assign lsu_awvalid   = state == ADDR && store_q;
	assign lsu_awid      = `ID_W'(`LSU_ID);
	assign lsu_awlen     = 8'd0;
	assign lsu_awsize    = op_size(op_q);
	assign lsu_awburst   = BURST_INCR;
	assign lsu_axi_wdata = wdata_q;
	assign lsu_wstrb     = strb_q;
	assign lsu_wvalid    = state == ADDR && store_q; // Raised with awvalid
	assign lsu_wlast     = 1'b1;
	assign lsu_bready    = state == RESP && store_q;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= IDLE;
			lsu_done <= 1'b0;
			lsu_err <= 1'b0;
		end else begin
			lsu_done <= 1'b0;
			case (state)
				IDLE: begin
					if (lsu_req && misaligned) begin
						lsu_done <= 1'b1;
						lsu_err <= 1'b1;
					end else if (lsu_req) begin
						state <= ADDR;
					end
				end
				ADDR: begin
					if (lsu_arvalid && lsu_arready) begin
						state <= RESP;
					end else if (lsu_awvalid && lsu_awready && lsu_wready) begin
						state <= RESP;
					end
				end
				RESP: begin
					if (lsu_rvalid && !store_q) begin
						lsu_done <= 1'b1;
						lsu_err <= lsu_rresp != OKAY || !lsu_rlast ||
							lsu_rid != `ID_W'(`LSU_ID);
						state <= IDLE;
					end else if (lsu_bvalid && store_q) begin
						lsu_done <= 1'b1;
						lsu_err <= lsu_bresp != OKAY || lsu_bid != `ID_W'(`LSU_ID);
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && lsu_req) begin
			op_q <= lsu_op;
			addr_q <= lsu_addr;
			case (op_size(lsu_op))
				SZ_BYTE: begin
					wdata_q <= {4{lsu_wdata[7:0]}};
					strb_q <= 4'b0001 << lsu_addr[1:0];
				end
				SZ_HALF: begin
					wdata_q <= {2{lsu_wdata[15:0]}};
					strb_q <= 4'b0011 << lsu_addr[1:0];
				end
				default: begin
					wdata_q <= lsu_wdata;
					strb_q <= 4'b1111;
				end
			endcase
		end
		if (state == IDLE && lsu_req && misaligned) begin
			lsu_rdata <= '0;
		end else if (state == RESP && lsu_rvalid && !store_q) begin
			lsu_rdata <= load_val;
		end
	end

	// A pending write request holds both valids and its address
	assert property (@(posedge clk) disable iff (!rst)
		lsu_awvalid && !lsu_awready |=> lsu_awvalid && lsu_wvalid && $stable(lsu_awaddr));

endmodule

//--- arbiter/axi_arbiter.sv
`include "mem_config.svh"

module axi_arbiter import axi_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`ADDR_W-1:0]    ifu_araddr,
	input  logic                  ifu_arvalid,
	output logic                  ifu_arready,
	input  logic [`ID_W-1:0]      ifu_arid,
	input  logic [7:0]            ifu_arlen,
	input  axi_size_t             ifu_arsize,
	input  logic [1:0]            ifu_arburst,
	output logic [`DATA_W-1:0]    ifu_rdata,
	output axi_resp_t             ifu_rresp,
	output logic                  ifu_rvalid,
	input  logic                  ifu_rready,
	output logic                  ifu_rlast,
	output logic [`ID_W-1:0]      ifu_rid,
	input  logic [`ADDR_W-1:0]    ifu_awaddr,
	input  logic                  ifu_awvalid,
	output logic                  ifu_awready,
	input  logic [`ID_W-1:0]      ifu_awid,
	input  logic [7:0]            ifu_awlen,
	input  axi_size_t             ifu_awsize,
	input  logic [1:0]            ifu_awburst,
	input  logic [`DATA_W-1:0]    ifu_wdata,
	input  logic [`DATA_W/8-1:0]  ifu_wstrb,
	input  logic                  ifu_wvalid,
	input  logic                  ifu_wlast,
	output logic                  ifu_wready,
	output axi_resp_t             ifu_bresp,
	output logic                  ifu_bvalid,
	output logic [`ID_W-1:0]      ifu_bid,
	input  logic                  ifu_bready,
	input  logic [`ADDR_W-1:0]    lsu_araddr,
	input  logic                  lsu_arvalid,
	output logic                  lsu_arready,
	input  logic [`ID_W-1:0]      lsu_arid,
	input  logic [7:0]            lsu_arlen,
	input  axi_size_t             lsu_arsize,
	input  logic [1:0]            lsu_arburst,
	output logic [`DATA_W-1:0]    lsu_axi_rdata,
	output axi_resp_t             lsu_rresp,
	output logic                  lsu_rvalid,
	input  logic                  lsu_rready,
	output logic                  lsu_rlast,
	output logic [`ID_W-1:0]      lsu_rid,
	input  logic [`ADDR_W-1:0]    lsu_awaddr,
	input  logic                  lsu_awvalid,
	output logic                  lsu_awready,
	input  logic [`ID_W-1:0]      lsu_awid,
	input  logic [7:0]            lsu_awlen,
	input  axi_size_t             lsu_awsize,
	input  logic [1:0]            lsu_awburst,
	input  logic [`DATA_W-1:0]    lsu_axi_wdata,
	input  logic [`DATA_W/8-1:0]  lsu_wstrb,
	input  logic                  lsu_wvalid,
	input  logic                  lsu_wlast,
	output logic                  lsu_wready,
	output axi_resp_t             lsu_bresp,
	output logic                  lsu_bvalid,
	output logic [`ID_W-1:0]      lsu_bid,
	input  logic                  lsu_bready,
	output logic [`ADDR_W-1:0]    araddr,
	output logic                  arvalid,
	input  logic                  arready,
	output logic [`ID_W-1:0]      arid,
	output logic [7:0]            arlen,
	output axi_size_t             arsize,
	output logic [1:0]            arburst,
	input  logic [`DATA_W-1:0]    rdata,
	input  axi_resp_t             rresp,
	input  logic                  rvalid,
	output logic                  rready,
	input  logic                  rlast,
	input  logic [`ID_W-1:0]      rid,
	output logic [`ADDR_W-1:0]    awaddr,
	output logic                  awvalid,
	input  logic                  awready,
	output logic [`ID_W-1:0]      awid,
	output logic [7:0]            awlen,
	output axi_size_t             awsize,
	output logic [1:0]            awburst,
	output logic [`DATA_W-1:0]    wdata,
	output logic [`DATA_W/8-1:0]  wstrb,
	output logic                  wvalid,
	output logic                  wlast,
	input  logic                  wready,
	input  axi_resp_t             bresp,
	input  logic                  bvalid,
	input  logic [`ID_W-1:0]      bid,
	output logic                  bready
);
	typedef enum logic [1:0] {IDLE, SERVE_IFU, SERVE_LSU} state_t;

	state_t state;
	logic ifu_trigger;
	logic lsu_trigger;
	logic gnt_ifu;
	logic gnt_lsu;
	logic resp_hs;

	assign ifu_trigger = ifu_arvalid || (ifu_awvalid && ifu_wvalid);
	assign lsu_trigger = lsu_arvalid || (lsu_awvalid && lsu_wvalid);
	assign gnt_ifu = state == SERVE_IFU;
	assign gnt_lsu = state == SERVE_LSU;
	assign resp_hs = (rvalid && rready) || (bvalid && bready); // End of transaction

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (ifu_trigger) begin // Fetch has priority
						state <= SERVE_IFU;
					end else if (lsu_trigger) begin
						state <= SERVE_LSU;
					end
				end
				SERVE_IFU, SERVE_LSU: begin
					if (resp_hs) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Request side follows the grant and is low in IDLE
	assign araddr  = gnt_ifu ? ifu_araddr : gnt_lsu ? lsu_araddr : '0;
	assign arvalid = gnt_ifu ? ifu_arvalid : gnt_lsu && lsu_arvalid;
	assign arid    = gnt_ifu ? ifu_arid : gnt_lsu ? lsu_arid : '0;
	assign arlen   = gnt_ifu ? ifu_arlen : gnt_lsu ? lsu_arlen : '0;
	assign arsize  = gnt_ifu ? ifu_arsize : gnt_lsu ? lsu_arsize : SZ_BYTE;
	assign arburst = gnt_ifu ? ifu_arburst : gnt_lsu ? lsu_arburst : '0;
	assign rready  = gnt_ifu ? ifu_rready : gnt_lsu && lsu_rready;
	assign awaddr  = gnt_ifu ? ifu_awaddr : gnt_lsu ? lsu_awaddr : '0;
	assign awvalid = gnt_ifu ? ifu_awvalid : gnt_lsu && lsu_awvalid;
	assign awid    = gnt_ifu ? ifu_awid : gnt_lsu ? lsu_awid : '0;
	assign awlen   = gnt_ifu ? ifu_awlen : gnt_lsu ? lsu_awlen : '0;
	assign awsize  = gnt_ifu ? ifu_awsize : gnt_lsu ? lsu_awsize : SZ_BYTE;
	assign awburst = gnt_ifu ? ifu_awburst : gnt_lsu ? lsu_awburst : '0;
	assign wdata   = gnt_ifu ? ifu_wdata : gnt_lsu ? lsu_axi_wdata : '0;
	assign wstrb   = gnt_ifu ? ifu_wstrb : gnt_lsu ? lsu_wstrb : '0;
	assign wvalid  = gnt_ifu ? ifu_wvalid : gnt_lsu && lsu_wvalid;
	assign wlast   = gnt_ifu ? ifu_wlast : gnt_lsu && lsu_wlast;
	assign bready  = gnt_ifu ? ifu_bready : gnt_lsu && lsu_bready;

	assign ifu_arready = gnt_ifu && arready;
	assign ifu_rdata   = gnt_ifu ? rdata : '0;
	assign ifu_rresp   = gnt_ifu ? rresp : OKAY;
	assign ifu_rvalid  = gnt_ifu && rvalid;
	assign ifu_rlast   = gnt_ifu && rlast;
	assign ifu_rid     = gnt_ifu ? rid : '0;
	assign ifu_awready = gnt_ifu && awready;
	assign ifu_wready  = gnt_ifu && wready;
	assign ifu_bresp   = gnt_ifu ? bresp : OKAY;
	assign ifu_bvalid  = gnt_ifu && bvalid;
	assign ifu_bid     = gnt_ifu ? bid : '0;

	assign lsu_arready   = gnt_lsu && arready;
	assign lsu_axi_rdata = gnt_lsu ? rdata : '0;
	assign lsu_rresp     = gnt_lsu ? rresp : OKAY;
	assign lsu_rvalid    = gnt_lsu && rvalid;
	assign lsu_rlast     = gnt_lsu && rlast;
	assign lsu_rid       = gnt_lsu ? rid : '0;
	assign lsu_awready   = gnt_lsu && awready;
	assign lsu_wready    = gnt_lsu && wready;
	assign lsu_bresp     = gnt_lsu ? bresp : OKAY;
	assign lsu_bvalid    = gnt_lsu && bvalid;
	assign lsu_bid       = gnt_lsu ? bid : '0;

	// Slave must be quiet between grants
	assert property (@(posedge clk) disable iff (!rst)
		state == IDLE |-> !(rvalid || bvalid));

	assert property (@(posedge clk) disable iff (!rst)
		(rvalid && !rready) || (bvalid && !bready) |=> $stable(state));

endmodule

//--- sram/axi_sram.sv
`include "mem_config.svh"

module axi_sram import axi_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`ADDR_W-1:0]    araddr,
	input  logic                  arvalid,
	output logic                  arready,
	input  logic [`ID_W-1:0]      arid,
	input  logic [7:0]            arlen,
	input  axi_size_t             arsize,
	input  logic [1:0]            arburst,
	output logic [`DATA_W-1:0]    rdata,
	output axi_resp_t             rresp,
	output logic                  rvalid,
	input  logic                  rready,
	output logic                  rlast,
	output logic [`ID_W-1:0]      rid,
	input  logic [`ADDR_W-1:0]    awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [`ID_W-1:0]      awid,
	input  logic [7:0]            awlen,
	input  axi_size_t             awsize,
	input  logic [1:0]            awburst,
	input  logic [`DATA_W-1:0]    wdata,
	input  logic [`DATA_W/8-1:0]  wstrb,
	input  logic                  wvalid,
	input  logic                  wlast,
	output logic                  wready,
	output axi_resp_t             bresp,
	output logic                  bvalid,
	output logic [`ID_W-1:0]      bid,
	input  logic                  bready
);
	localparam int IDX_W = $clog2(`MEM_WORDS);
	localparam int CNT_W = $clog2(`SRAM_LAT + 1);

	typedef enum logic [1:0] {IDLE, READ_WAIT, WRITE_WAIT, RESP} state_t;

	state_t state;
	logic [`DATA_W-1:0] mem [`MEM_WORDS];
	logic [CNT_W-1:0] cnt;
	logic [`ADDR_W-1:0] addr_q;
	logic [`ID_W-1:0] id_q;
	logic [`DATA_W-1:0] rdata_q;
	logic err_q;
	logic wr_q;
	logic rd_acc;
	logic wr_acc;
	logic wr_bad;

	// Out of range, a burst, or an address off its size
	function automatic logic bad_req(input logic [`ADDR_W-1:0] addr, input logic [7:0] len,
		input axi_size_t size);
		logic off;
		off = (size == SZ_HALF && addr[0]) || (size == SZ_WORD && addr[1:0] != 2'b00);
		return addr >= `ADDR_W'(`MEM_WORDS * 4) || len != 8'd0 || off;
	endfunction

	assign arready = state == IDLE;
	assign awready = state == IDLE && awvalid && wvalid;
	assign wready  = awready;
	assign rd_acc  = arvalid && arready;
	assign wr_acc  = awvalid && awready;
	assign wr_bad  = bad_req(awaddr, awlen, awsize) || !wlast;

	assign rvalid = state == RESP && !wr_q;
	assign rdata  = rdata_q;
	assign rresp  = err_q ? SLVERR : OKAY;
	assign rlast  = 1'b1;
	assign rid    = id_q;
	assign bvalid = state == RESP && wr_q;
	assign bresp  = err_q ? SLVERR : OKAY;
	assign bid    = id_q;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (rd_acc) begin
						state <= READ_WAIT;
						cnt <= CNT_W'(`SRAM_LAT - 1);
					end else if (wr_acc) begin
						state <= WRITE_WAIT;
						cnt <= CNT_W'(`SRAM_LAT - 1);
					end
				end
				READ_WAIT, WRITE_WAIT: begin
					if (cnt == CNT_W'(1)) begin
						state <= RESP;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				RESP: begin
					if ((rvalid && rready) || (bvalid && bready)) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_acc) begin
			addr_q <= araddr;
			id_q <= arid;
			err_q <= bad_req(araddr, arlen, arsize);
			wr_q <= 1'b0;
		end else if (wr_acc) begin
			addr_q <= awaddr;
			id_q <= awid;
			err_q <= wr_bad;
			wr_q <= 1'b1;
		end
		if (state == READ_WAIT && cnt == CNT_W'(1)) begin
			rdata_q <= err_q ? '0 : mem[addr_q[IDX_W+1:2]]; // Error reads return zero
		end
	end

	// Byte-strobed write on accept, memory untouched on error
	always_ff @(posedge clk) begin
		if (wr_acc && !wr_bad) begin
			for (int i = 0; i < `DATA_W / 8; i++) begin
				if (wstrb[i]) begin
					mem[awaddr[IDX_W+1:2]][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

	// Only one master is granted at a time upstream
	assert property (@(posedge clk) disable iff (!rst)
		!(arvalid && arready && awvalid && awready));

endmodule

//--- hw/mem_subsys.sv
`include "mem_config.svh"

module mem_subsys import axi_pkg::*, mem_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                fetch_req,
	input  logic [`ADDR_W-1:0]  fetch_addr,
	output logic                fetch_busy,
	output logic                fetch_done,
	output logic [`DATA_W-1:0]  fetch_data,
	output logic                fetch_err,
	input  logic                lsu_req,
	input  lsu_op_t             lsu_op,
	input  logic [`ADDR_W-1:0]  lsu_addr,
	input  logic [`DATA_W-1:0]  lsu_wdata,
	output logic                lsu_busy,
	output logic                lsu_done,
	output logic [`DATA_W-1:0]  lsu_rdata,
	output logic                lsu_err
);
	logic [`ADDR_W-1:0] ifu_araddr, ifu_awaddr, lsu_araddr, lsu_awaddr, araddr, awaddr;
	logic [`DATA_W-1:0] ifu_rdata, ifu_wdata, lsu_axi_rdata, lsu_axi_wdata, rdata, wdata;
	logic [`DATA_W/8-1:0] ifu_wstrb, lsu_wstrb, wstrb;
	logic [`ID_W-1:0] ifu_arid, ifu_rid, ifu_awid, ifu_bid;
	logic [`ID_W-1:0] lsu_arid, lsu_rid, lsu_awid, lsu_bid;
	logic [`ID_W-1:0] arid, rid, awid, bid;
	logic [7:0] ifu_arlen, ifu_awlen, lsu_arlen, lsu_awlen, arlen, awlen;
	logic [1:0] ifu_arburst, ifu_awburst, lsu_arburst, lsu_awburst, arburst, awburst;
	axi_size_t ifu_arsize, ifu_awsize, lsu_arsize, lsu_awsize, arsize, awsize;
	axi_resp_t ifu_rresp, ifu_bresp, lsu_rresp, lsu_bresp, rresp, bresp;
	logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready, ifu_rlast, ifu_awvalid;
	logic ifu_awready, ifu_wvalid, ifu_wlast, ifu_wready, ifu_bvalid, ifu_bready;
	logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready, lsu_rlast, lsu_awvalid;
	logic lsu_awready, lsu_wvalid, lsu_wlast, lsu_wready, lsu_bvalid, lsu_bready;
	logic arvalid, arready, rvalid, rready, rlast, awvalid;
	logic awready, wvalid, wlast, wready, bvalid, bready;

	// Bundles share port names, so implicit connections suffice
	ifu_fetch_port u_ifu (.*);

	lsu_access_port u_lsu (.*);

	axi_arbiter u_arb (.*);

	axi_sram u_sram (.*);

endmodule

//--- test/tb_mem_subsys.sv
`include "mem_config.svh"

module tb_mem_subsys import mem_pkg::*; ();
	localparam int N_OPS = 336; // Bus operations over all tests
	localparam logic [31:0] MEM_END = `MEM_WORDS * 4;

	logic clk = 1'b0;
	logic rst;
	logic fetch_req;
	logic [`ADDR_W-1:0] fetch_addr;
	logic fetch_busy;
	logic fetch_done;
	logic [`DATA_W-1:0] fetch_data;
	logic fetch_err;
	logic lsu_req;
	lsu_op_t lsu_op;
	logic [`ADDR_W-1:0] lsu_addr;
	logic [`DATA_W-1:0] lsu_wdata;
	logic lsu_busy;
	logic lsu_done;
	logic [`DATA_W-1:0] lsu_rdata;
	logic lsu_err;

	logic [31:0] ref_mem [`MEM_WORDS];
	logic [31:0] pool [$]; // Words with known contents
	int unsigned rng_state = 20502;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_start_errs = 0;
	int fetch_sent = 0;
	int fetch_seen = 0;
	int lsu_sent = 0;
	int lsu_seen = 0;
	logic fetch_pend = 1'b0;
	logic [31:0] fetch_pend_addr;
	logic lsu_pend = 1'b0;
	lsu_op_t lsu_pend_op;
	logic [31:0] lsu_pend_addr;
	logic [31:0] lsu_pend_wdata;
	time fetch_done_t;
	time lsu_done_t;

	mem_subsys u_dut (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return {rng_state[15:0], rng_state[31:16]}; // Low LCG bits repeat quickly
	endfunction

	function automatic int access_bytes(input lsu_op_t op);
		case (op)
			LB, LBU, SB: return 1;
			LH, LHU, SH: return 2;
			default: return 4;
		endcase
	endfunction

	// Expected error flag and load data of an access
	function automatic logic [32:0] ref_access(input lsu_op_t op, input logic [31:0] addr);
		logic [31:0] w;
		logic [7:0] b;
		logic [15:0] h;
		int n;
		n = access_bytes(op);
		if (addr >= MEM_END || (n == 2 && addr[0]) || (n == 4 && addr[1:0] != 2'b00)) begin
			return {1'b1, 32'h0};
		end
		w = ref_mem[addr[11:2]];
		b = w[addr[1:0]*8 +: 8];
		h = w[addr[1]*16 +: 16];
		case (op)
			LB: return {1'b0, {24{b[7]}}, b};
			LBU: return {1'b0, 24'h0, b};
			LH: return {1'b0, {16{h[15]}}, h};
			LHU: return {1'b0, 16'h0, h};
			default: return {1'b0, w};
		endcase
	endfunction

	task automatic apply_store(input lsu_op_t op, input logic [31:0] addr, input logic [31:0] d);
		case (access_bytes(op))
			1: ref_mem[addr[11:2]][addr[1:0]*8 +: 8] = d[7:0];
			2: ref_mem[addr[11:2]][addr[1]*16 +: 16] = d[15:0];
			default: ref_mem[addr[11:2]] = d;
		endcase
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL at %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Every done pulse is checked against the reference model in completion order
	always @(negedge clk) begin
		logic [32:0] expected;
		if (rst && fetch_done) begin
			if (!fetch_pend) begin
				errors++;
				$display("Error at %0t: fetch_done pulsed with no fetch pending", $time);
			end else begin
				expected = ref_access(LW, fetch_pend_addr);
				check("fetch_data", fetch_data, expected[31:0]);
				check("fetch_err", 32'(fetch_err), 32'(expected[32]));
				fetch_pend = 1'b0;
				fetch_done_t = $time;
				fetch_seen++;
			end
		end
		if (rst && lsu_done) begin
			if (!lsu_pend) begin
				errors++;
				$display("Error at %0t: lsu_done pulsed with no access pending", $time);
			end else begin
				expected = ref_access(lsu_pend_op, lsu_pend_addr);
				check("lsu_err", 32'(lsu_err), 32'(expected[32]));
				if (lsu_pend_op inside {SB, SH, SW}) begin
					if (!expected[32]) begin
						apply_store(lsu_pend_op, lsu_pend_addr, lsu_pend_wdata);
					end
				end else begin
					check("lsu_rdata", lsu_rdata, expected[31:0]);
				end
				lsu_pend = 1'b0;
				lsu_done_t = $time;
				lsu_seen++;
			end
		end
	end

	task automatic fetch_word(input logic [31:0] addr);
		@(posedge clk);
		fetch_req <= 1'b1;
		fetch_addr <= addr;
		fetch_pend_addr = addr;
		fetch_pend = 1'b1;
		fetch_sent++;
		@(posedge clk);
		fetch_req <= 1'b0;
		wait (fetch_seen == fetch_sent);
	endtask

	task automatic lsu_access(input lsu_op_t op, input logic [31:0] addr, input logic [31:0] d);
		@(posedge clk);
		lsu_req <= 1'b1;
		lsu_op <= op;
		lsu_addr <= addr;
		lsu_wdata <= d;
		lsu_pend_op = op;
		lsu_pend_addr = addr;
		lsu_pend_wdata = d;
		lsu_pend = 1'b1;
		lsu_sent++;
		@(posedge clk);
		lsu_req <= 1'b0;
		wait (lsu_seen == lsu_sent);
	endtask

	task automatic idle_gap();
		repeat (next_rand() & 32'd7) @(posedge clk);
	endtask

	task automatic random_fetch();
		logic [31:0] r;
		r = next_rand();
		case (r[3:0])
			4'd0: fetch_word(pool[r[8:4]] | MEM_END);
			4'd1: fetch_word(pool[r[8:4]] | 32'd2);
			default: fetch_word(pool[r[8:4]]);
		endcase
	endtask

	task automatic random_lsu();
		logic [31:0] r;
		logic [31:0] addr;
		r = next_rand();
		addr = {pool[r[9:5]][31:2], r[1:0]};
		if (r[13:10] == 4'd0) begin
			addr = addr | MEM_END; // Occasional out-of-range access
		end
		lsu_access(lsu_op_t'({1'b0, r[18:16]}), addr, next_rand());
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_start_errs) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d errors", tests, name, errors - test_start_errs);
		end
		test_start_errs = errors;
	endtask

	task automatic word_store_fetch();
		logic [31:0] addr;
		repeat (32) begin
			addr = next_rand() & 32'h0000_0FFC;
			pool.push_back(addr);
			lsu_access(SW, addr, next_rand());
		end
		foreach (pool[i]) begin
			fetch_word(pool[i]);
		end
		finish_test("word store and fetch");
	endtask

	task automatic subword_stores();
		logic [31:0] base;
		logic [31:0] r;
		repeat (8) begin
			base = next_rand() & 32'h0000_0FFC;
			r = next_rand();
			lsu_access(SW, base, next_rand());
			lsu_access(SB, {base[31:2], r[1:0]}, r);
			lsu_access(SH, {base[31:2], r[2], 1'b0}, r >> 8);
			lsu_access(LW, base, 32'h0);
		end
		finish_test("sub-word stores");
	endtask

	task automatic load_extension();
		logic [31:0] pats [2];
		logic [31:0] base;
		pats = '{32'h807F_FF01, 32'h7F80_01FF}; // Top bits set and clear
		base = pool[0];
		foreach (pats[p]) begin
			lsu_access(SW, base, pats[p]);
			for (int k = 0; k < 4; k++) begin
				lsu_access(LB, {base[31:2], 2'(k)}, 32'h0);
				lsu_access(LBU, {base[31:2], 2'(k)}, 32'h0);
			end
			for (int k = 0; k < 2; k++) begin
				lsu_access(LH, {base[31:2], 1'(k), 1'b0}, 32'h0);
				lsu_access(LHU, {base[31:2], 1'(k), 1'b0}, 32'h0);
			end
		end
		finish_test("load extension");
	endtask

	task automatic error_cases();
		logic [31:0] base;
		base = pool[1];
		lsu_access(SW, base, 32'hA5C3_3C5A);
		lsu_access(LH, base | 32'd1, 32'h0);
		lsu_access(LW, base | 32'd2, 32'h0);
		lsu_access(SH, base | 32'd3, 32'hFFFF_FFFF);
		lsu_access(SW, base | 32'd1, 32'hFFFF_FFFF);
		fetch_word(base | 32'd2);
		lsu_access(LW, base, 32'h0);
		lsu_access(SB, MEM_END, 32'h11);
		lsu_access(SW, MEM_END | pool[2], 32'h1234_5678); // Would alias pool[2] if it wrapped
		lsu_access(LW, pool[2], 32'h0);
		lsu_access(LW, MEM_END, 32'h0);
		fetch_word(MEM_END + 32'd8);
		finish_test("error cases");
	endtask

	task automatic fetch_lsu_contention();
		fork
			fetch_word(pool[2]);
			lsu_access(LW, pool[3], 32'h0);
		join
		check("fetch_done before lsu_done", 32'(fetch_done_t < lsu_done_t), 32'd1);
		fork
			repeat (100) begin
				idle_gap();
				random_fetch();
			end
			repeat (100) begin
				idle_gap();
				random_lsu();
			end
		join
		finish_test("contention");
	endtask

	initial begin
		repeat (16 + N_OPS * 40) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", 16 + N_OPS * 40);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		rst = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		lsu_req = 1'b0;
		lsu_op = LW;
		lsu_addr = '0;
		lsu_wdata = '0;
		repeat (15) @(posedge clk);
		@(negedge clk);
		check("idle under reset", 32'({fetch_done, lsu_done, fetch_busy, lsu_busy}), 32'd0);
		@(posedge clk);
		rst <= 1'b1;
		word_store_fetch();
		subword_stores();
		load_extension();
		error_cases();
		fetch_lsu_contention();
		repeat (4) @(posedge clk);
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- mem_subsys.f
+incdir+common
common/axi_pkg.sv
common/mem_pkg.sv
hw/ifu_fetch_port.sv
hw/lsu_access_port.sv
arbiter/axi_arbiter.sv
sram/axi_sram.sv
hw/mem_subsys.sv
test/tb_mem_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= mem_subsys.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(BUILD_DIR)
